/* common/fpu_pkg.sv */
package fpu_pkg;

    // operand and result width
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    // single precision field layout
    localparam int MANT_W = 23;

    // biased exponent of 1.0
    localparam int EXP_BIAS = 127;

    // biased exponent of 2^31, where ftoi saturates
    localparam int EXP_INT_MAX = 158;

    localparam word_t INT_POS_MAX = 32'h7fff_ffff;
    localparam word_t INT_NEG_MAX = 32'h8000_0000;

    // func7 opcodes handled by the unit
    typedef enum logic [6:0] {
        FUNC7_FSGNJ = 7'h10,
        FUNC7_FCOMP = 7'h50,
        FUNC7_FTOI  = 7'h60,
        FUNC7_ITOF  = 7'h68,
        FUNC7_FMVI  = 7'h70,
        FUNC7_IMVF  = 7'h78
    } fpu_func7_e;

    // func3 for sign injection
    typedef enum logic [2:0] {
        SGNJ_J  = 3'd0,
        SGNJ_JN = 3'd1,
        SGNJ_JX = 3'd2
    } sgnj_mode_e;

    // func3 for comparison
    typedef enum logic [2:0] {
        CMP_FLE = 3'd0,
        CMP_FLT = 3'd1,
        CMP_FEQ = 3'd2
    } cmp_mode_e;

endpackage

/* common/fpu_op_if.sv */
`timescale 1ns/1ps

interface fpu_op_if import fpu_pkg::*; ();

    // request side, from the control module
    logic        order;
    word_t       rs1;
    word_t       rs2;
    logic [2:0]  func3;
    // set for comparison, clear for sign injection
    logic        sel;

    // answer side, from the datapath unit
    logic        accepted;
    logic        done;
    word_t       rd;

    modport ctrl (
        output order, rs1, rs2, func3, sel,
        input  accepted, done, rd
    );

    modport unit (
        input  order, rs1, rs2, func3, sel,
        output accepted, done, rd
    );

endinterface

/* hw/fp_sign_compare.sv */
`timescale 1ns/1ps

module fp_sign_compare import fpu_pkg::*; (
    fpu_op_if.unit op
);

    logic        sgn1;
    logic        sgn2;
    logic [30:0] mag1;
    logic [30:0] mag2;
    logic        sgn_res;
    logic        both_zero;
    logic        eq;
    logic        lt;
    logic        cmp_bit;

    assign sgn1 = op.rs1[31];
    assign sgn2 = op.rs2[31];
    assign mag1 = op.rs1[30:0];
    assign mag2 = op.rs2[30:0];

    // sign for fsgnj, fsgnjn, fsgnjx
    always_comb begin
        case (sgnj_mode_e'(op.func3))
            SGNJ_J:  sgn_res = sgn2;
            SGNJ_JN: sgn_res = ~sgn2;
            SGNJ_JX: sgn_res = sgn1 ^ sgn2;
            default: sgn_res = sgn1;
        endcase
    end

    // +0 and -0 compare equal
    assign both_zero = (mag1 == '0) && (mag2 == '0);
    assign eq = (op.rs1 == op.rs2) || both_zero;

    // sign and magnitude ordering
    always_comb begin
        if (sgn1 != sgn2) begin
            lt = sgn1 && !both_zero;
        end else if (sgn1) begin
            lt = mag1 > mag2;
        end else begin
            lt = mag1 < mag2;
        end
    end

    always_comb begin
        case (cmp_mode_e'(op.func3))
            CMP_FLE: cmp_bit = lt || eq;
            CMP_FLT: cmp_bit = lt;
            CMP_FEQ: cmp_bit = eq;
            default: cmp_bit = 1'b0;
        endcase
    end

    assign op.rd       = op.sel ? {31'b0, cmp_bit} : {sgn_res, mag1};
    // finishes in the order cycle
    assign op.accepted = op.order;
    assign op.done     = op.order;

endmodule

/* convert/fp_itof.sv */
`timescale 1ns/1ps

module fp_itof import fpu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    fpu_op_if.unit op
);

    typedef enum logic {
        ITOF_IDLE,
        ITOF_NORM
    } itof_state_e;

    itof_state_e state_q;
    logic        sign_q;
    word_t       mag_q;
    logic [7:0]  exp_q;
    logic        norm_end;
    word_t       abs_in;

    assign abs_in = op.rs1[31] ? (~op.rs1 + word_t'(1)) : op.rs1;

    // leading one reached, or nothing to normalise
    assign norm_end = (state_q == ITOF_NORM) && (mag_q[31] || mag_q == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ITOF_IDLE;
        end else begin
            case (state_q)
                ITOF_IDLE: if (op.order) state_q <= ITOF_NORM;
                ITOF_NORM: if (norm_end) state_q <= ITOF_IDLE;
                default:   state_q <= ITOF_IDLE;
            endcase
        end
    end

    // one bit per cycle, exponent counts down from 2^31
    always_ff @(posedge clk) begin
        if (state_q == ITOF_IDLE && op.order) begin
            sign_q <= op.rs1[31];
            mag_q  <= abs_in;
            exp_q  <= 8'(EXP_INT_MAX);
        end else if (state_q == ITOF_NORM && !norm_end) begin
            mag_q <= mag_q << 1;
            exp_q <= exp_q - 8'd1;
        end
    end

    assign op.accepted = op.order;
    assign op.done     = norm_end;
    // hidden bit dropped, low bits truncated
    assign op.rd       = (mag_q == '0) ? '0
                       : {sign_q, exp_q, mag_q[30 -: MANT_W]};

    // the control module never orders a busy converter
    a_order_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        op.order |-> (state_q == ITOF_IDLE)
    );

endmodule

/* convert/fp_ftoi.sv */
`timescale 1ns/1ps

module fp_ftoi import fpu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    fpu_op_if.unit op
);

    logic        sign;
    logic [7:0]  exp;
    word_t       mant;
    word_t       mag;
    word_t       res;
    word_t       rd_q;
    logic        done_q;

    assign sign = op.rs1[31];
    assign exp  = op.rs1[30:23];
    // significand with hidden bit
    assign mant = {8'b0, 1'b1, op.rs1[MANT_W-1:0]};

    // integer part by aligning the binary point
    always_comb begin
        if (exp >= 8'(EXP_BIAS + MANT_W)) begin
            mag = mant << (exp - 8'(EXP_BIAS + MANT_W));
        end else begin
            mag = mant >> (8'(EXP_BIAS + MANT_W) - exp);
        end
    end

    always_comb begin
        if (exp < 8'(EXP_BIAS)) begin
            res = '0;
        end else if (exp >= 8'(EXP_INT_MAX)) begin
            res = sign ? INT_NEG_MAX : INT_POS_MAX;
        end else begin
            res = sign ? (~mag + word_t'(1)) : mag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= op.order;
        end
    end

    always_ff @(posedge clk) begin
        if (op.order) rd_q <= res;
    end

    assign op.accepted = op.order;
    assign op.done     = done_q;
    assign op.rd       = rd_q;

endmodule

/* hw/fpu_ctrl.sv */
`timescale 1ns/1ps

module fpu_ctrl import fpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       order,
    output logic       accepted,
    output logic       done,

    input  logic [2:0] func3,
    input  fpu_func7_e func7,
    input  word_t      rs1,
    input  word_t      rs2,
    output word_t      rd,

    fpu_op_if.ctrl     sc,
    fpu_op_if.ctrl     itof,
    fpu_op_if.ctrl     ftoi
);

    typedef enum logic {
        CTRL_IDLE,
        CTRL_BUSY
    } ctrl_state_e;

    ctrl_state_e state_q;
    logic        order_ok;
    logic        sc_hit;
    logic        itof_hit;
    logic        ftoi_hit;
    logic        mv_hit;
    logic        none_hit;
    logic        self_done;
    word_t       rd_next;
    word_t       rd_q;

    // orders only pass while nothing is in flight
    assign order_ok = (state_q == CTRL_IDLE) && order;

    always_comb begin
        sc_hit   = 1'b0;
        itof_hit = 1'b0;
        ftoi_hit = 1'b0;
        mv_hit   = 1'b0;
        none_hit = 1'b0;
        case (func7)
            FUNC7_FSGNJ, FUNC7_FCOMP: sc_hit = 1'b1;
            FUNC7_ITOF: itof_hit = 1'b1;
            FUNC7_FTOI: ftoi_hit = 1'b1;
            FUNC7_FMVI, FUNC7_IMVF: mv_hit = 1'b1;
            default: none_hit = 1'b1;
        endcase
    end

    // operands go to every unit, order only to the decoded one
    assign sc.order   = order_ok && sc_hit;
    assign sc.rs1     = rs1;
    assign sc.rs2     = rs2;
    assign sc.func3   = func3;
    assign sc.sel     = (func7 == FUNC7_FCOMP);

    assign itof.order = order_ok && itof_hit;
    assign itof.rs1   = rs1;
    assign itof.rs2   = rs2;
    assign itof.func3 = func3;
    assign itof.sel   = 1'b0;

    assign ftoi.order = order_ok && ftoi_hit;
    assign ftoi.rs1   = rs1;
    assign ftoi.rs2   = rs2;
    assign ftoi.func3 = func3;
    assign ftoi.sel   = 1'b0;

    // raw moves and unknown opcodes finish here in the order cycle
    assign self_done = order_ok && (mv_hit || none_hit);

    assign accepted = sc.accepted | itof.accepted | ftoi.accepted | self_done;
    assign done     = sc.done | itof.done | ftoi.done | self_done;

    always_comb begin
        if (sc.done) begin
            rd_next = sc.rd;
        end else if (itof.done) begin
            rd_next = itof.rd;
        end else if (ftoi.done) begin
            rd_next = ftoi.rd;
        end else if (self_done && mv_hit) begin
            rd_next = rs1;
        end else begin
            rd_next = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CTRL_IDLE;
            rd_q    <= '0;
        end else begin
            if (done) begin
                state_q <= CTRL_IDLE;
                rd_q    <= rd_next;
            end else if (accepted) begin
                state_q <= CTRL_BUSY;
            end
        end
    end

    // live value in the done cycle, held value afterwards
    assign rd = done ? rd_next : rd_q;

    // a unit may only finish what it was given
    a_no_spurious_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == CTRL_IDLE && !order) |-> !done
    );

    a_single_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({sc.done, itof.done, ftoi.done, self_done})
    );

endmodule

/* hw/fpu.sv */
`timescale 1ns/1ps

module fpu import fpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       order,
    output logic       accepted,
    output logic       done,

    input  logic [2:0] func3,
    input  fpu_func7_e func7,
    input  word_t      rs1,
    input  word_t      rs2,

    output word_t      rd
);

    // one handshake channel per datapath unit
    fpu_op_if sc_if ();
    fpu_op_if itof_if ();
    fpu_op_if ftoi_if ();

    // decode, routing and result hold
    fpu_ctrl m_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .order    (order),
        .accepted (accepted),
        .done     (done),
        .func3    (func3),
        .func7    (func7),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .sc       (sc_if.ctrl),
        .itof     (itof_if.ctrl),
        .ftoi     (ftoi_if.ctrl)
    );

    // fsgnj family and feq/flt/fle
    fp_sign_compare m_sign_compare (
        .op (sc_if.unit)
    );

    fp_itof m_itof (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (itof_if.unit)
    );

    fp_ftoi m_ftoi (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (ftoi_if.unit)
    );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held low over the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* sim/tb_fpu.sv */
`timescale 1ns/1ps

module tb_fpu import fpu_pkg::*; ();

    localparam int TIMEOUT = 64;
    // itof latency depends on the operand
    localparam int LAT_ANY = -1;
    localparam int ITOF_MAX_LAT = 33;

    typedef struct packed {
        fpu_func7_e f7;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      want;
        int         lat;
    } vec_t;

    logic       clk;
    logic       rst_n;
    logic       order;
    logic       accepted;
    logic       done;
    logic [2:0] func3;
    fpu_func7_e func7;
    word_t      rs1;
    word_t      rs2;
    word_t      rd;

    vec_t   vecs[$];
    integer seed;
    int     errors;
    int     tests;
    int     failed;
    int     cyc;
    int     err_start;
    int     lat;
    int     r;
    bit     ok;
    word_t  res;
    word_t  held;
    word_t  fval;

    tb_clock m_clock (.clk(clk), .rst_n(rst_n));

    fpu i_fpu (
        .clk      (clk),
        .rst_n    (rst_n),
        .order    (order),
        .accepted (accepted),
        .done     (done),
        .func3    (func3),
        .func7    (func7),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd)
    );

    task automatic add_vec(input fpu_func7_e f7, input logic [2:0] f3, input word_t a,
                           input word_t b, input word_t want, input int lat_exp);
        vecs.push_back({f7, f3, a, b, want, lat_exp});
    endtask

    task automatic check_rd(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            $display("FAILED %s got=%h expected=%h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_latency(input int got, input int want);
        if (got != want) begin
            $display("FAILED latency got=%0h expected=%0h", got, want);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("FAILED %s got=%h expected=%h", name, got, want);
            errors++;
        end
    endtask

    task automatic report_test(input string what);
        tests++;
        if (errors != err_start) begin
            failed++;
            $display("test %0d %s: fail", tests, what);
        end else begin
            $display("test %0d %s: pass", tests, what);
        end
    endtask

    // drive on the falling edge, sample 10 ns before the rising edge
    task automatic run_op(input fpu_func7_e f7, input logic [2:0] f3, input word_t a,
                          input word_t b, output word_t result, output int cycles,
                          output word_t hold, output bit good);
        int  n;
        bit  got_acc;
        bit  got_done;
        good = 1'b1;
        cycles = 0;
        result = '0;
        hold = '0;
        got_acc = 1'b0;
        got_done = 1'b0;
        n = 0;
        @(negedge clk);
        func7 = f7;
        func3 = f3;
        rs1 = a;
        rs2 = b;
        order = 1'b1;
        while (!got_acc && n < TIMEOUT) begin
            #40;
            if (accepted) begin
                got_acc = 1'b1;
                got_done = done;
                result = rd;
            end
            @(negedge clk);
            n++;
        end
        order = 1'b0;
        if (!got_acc) begin
            $display("The order was not accepted within %0d cycles.", TIMEOUT);
            errors++;
            good = 1'b0;
            return;
        end
        n = 0;
        while (!got_done && n < TIMEOUT) begin
            #40;
            cycles++;
            if (done) begin
                got_done = 1'b1;
                result = rd;
            end
            @(negedge clk);
            n++;
        end
        if (!got_done) begin
            $display("No done arrived within %0d cycles of accepted.", TIMEOUT);
            errors++;
            good = 1'b0;
            return;
        end
        // one idle cycle later rd must still show the result
        #40;
        hold = rd;
    endtask

    initial begin
        order = 1'b0;
        func3 = '0;
        func7 = FUNC7_FSGNJ;
        rs1 = '0;
        rs2 = '0;
        seed = 32'hca80_9b4c;
        errors = 0;
        tests = 0;
        failed = 0;

        add_vec(FUNC7_FSGNJ, SGNJ_J,  32'h3f80_0000, 32'hc000_0000, 32'hbf80_0000, 0);
        add_vec(FUNC7_FSGNJ, SGNJ_JN, 32'hbfc0_0000, 32'hc000_0000, 32'h3fc0_0000, 0);
        add_vec(FUNC7_FSGNJ, SGNJ_JX, 32'hbf80_0000, 32'hc040_0000, 32'h3f80_0000, 0);
        add_vec(FUNC7_FCOMP, CMP_FEQ, 32'h0000_0000, 32'h8000_0000, 32'h1, 0);
        add_vec(FUNC7_FCOMP, CMP_FLT, 32'h0000_0000, 32'h8000_0000, 32'h0, 0);
        add_vec(FUNC7_FCOMP, CMP_FLE, 32'h8000_0000, 32'h0000_0000, 32'h1, 0);
        add_vec(FUNC7_FCOMP, CMP_FLT, 32'hbf80_0000, 32'h3f80_0000, 32'h1, 0);
        add_vec(FUNC7_FCOMP, CMP_FLT, 32'hc000_0000, 32'hbf80_0000, 32'h1, 0);
        add_vec(FUNC7_FCOMP, CMP_FLE, 32'h4000_0000, 32'h3fc0_0000, 32'h0, 0);
        add_vec(FUNC7_FTOI, 3'd0, 32'h3f00_0000, '0, 32'h0000_0000, 1);
        add_vec(FUNC7_FTOI, 3'd0, 32'h3fc0_0000, '0, 32'h0000_0001, 1);
        add_vec(FUNC7_FTOI, 3'd0, 32'hc020_0000, '0, 32'hffff_fffe, 1);
        add_vec(FUNC7_FTOI, 3'd0, 32'h4eff_ffff, '0, 32'h7fff_ff80, 1);
        add_vec(FUNC7_FTOI, 3'd0, 32'h4f00_0000, '0, 32'h7fff_ffff, 1);
        add_vec(FUNC7_FTOI, 3'd0, 32'hcf00_0000, '0, 32'h8000_0000, 1);
        add_vec(FUNC7_ITOF, 3'd0, 32'h0000_0001, '0, 32'h3f80_0000, LAT_ANY);
        add_vec(FUNC7_ITOF, 3'd0, 32'hffff_fffe, '0, 32'hc000_0000, LAT_ANY);
        add_vec(FUNC7_ITOF, 3'd0, 32'h7fff_ffff, '0, 32'h4eff_ffff, LAT_ANY);
        add_vec(FUNC7_ITOF, 3'd0, 32'h0000_0000, '0, 32'h0000_0000, LAT_ANY);
        add_vec(FUNC7_FMVI, 3'd0, 32'hc049_0fdb, '0, 32'hc049_0fdb, 0);
        add_vec(FUNC7_IMVF, 3'd0, 32'h1234_5678, '0, 32'h1234_5678, 0);
        add_vec(fpu_func7_e'(7'h22), 3'd0, 32'hdead_beef, '0, 32'h0, 0);

        // idle state right after reset
        err_start = errors;
        cyc = 0;
        while (rst_n !== 1'b1 && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released.");
            errors++;
        end
        #40;
        check_flag("accepted", accepted, 1'b0);
        check_flag("done", done, 1'b0);
        check_rd("rd", rd, '0);
        report_test("reset");

        foreach (vecs[i]) begin
            err_start = errors;
            run_op(vecs[i].f7, vecs[i].f3, vecs[i].a, vecs[i].b, res, lat, held, ok);
            if (ok) begin
                check_rd("rd", res, vecs[i].want);
                check_rd("rd held", held, vecs[i].want);
                if (vecs[i].lat == LAT_ANY) begin
                    if (lat > ITOF_MAX_LAT) begin
                        $display("The conversion took %0d cycles, more than allowed.", lat);
                        errors++;
                    end
                end else begin
                    check_latency(lat, vecs[i].lat);
                end
            end
            report_test($sformatf("func7=%h rs1=%h", vecs[i].f7, vecs[i].a));
        end

        // itof then ftoi is exact below 2^24
        for (int n = 0; n < 40; n++) begin
            err_start = errors;
            r = $random(seed) % 16777216;
            run_op(FUNC7_ITOF, 3'd0, word_t'(r), '0, fval, lat, held, ok);
            if (ok) begin
                if (lat > ITOF_MAX_LAT) begin
                    $display("The conversion took %0d cycles, more than allowed.", lat);
                    errors++;
                end
                run_op(FUNC7_FTOI, 3'd0, fval, '0, res, lat, held, ok);
                if (ok) begin
                    check_rd("rd", res, word_t'(r));
                    check_latency(lat, 1);
                end
            end
            report_test($sformatf("round trip %h", word_t'(r)));
        end

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* compile.f */
common/fpu_pkg.sv
common/fpu_op_if.sv
hw/fp_sign_compare.sv
convert/fp_itof.sv
convert/fp_ftoi.sv
hw/fpu_ctrl.sv
hw/fpu.sv
sim/tb_clock.sv
sim/tb_fpu.sv
